//--- source/fpalu_pkg.sv
/*
 * Common definitions for the FP29i add / FP16 multiply unit.
 * Holds the format widths and biases, the opcode encoding and the
 * vector types passed between pipeline stages.
 * Imported by wildcard in every module header of the unit.
 */
`default_nettype none

package fpalu_pkg;

	// FP29i: sign, 6b exponent, 22b right-aligned mantissa, no hidden bit
	localparam int FP29_EXP_W = 6;
	localparam int FP29_MAN_W = 22;
	localparam int FP29_BIAS  = 31;

	// FP16 fields ride in the low bits of the exponent and mantissa ports
	localparam int FP16_EXP_W  = 5;
	localparam int FP16_FRAC_W = 10;
	localparam int FP16_BIAS   = 15;

	localparam int BOOTH_DIGITS = 6;	// Radix-4 digits of an 11b operand

	typedef logic [FP29_EXP_W-1:0]  fp29_exp_t;
	typedef logic [FP29_MAN_W-1:0]  fp29_man_t;
	typedef logic [FP29_MAN_W:0]    sum_t;	// MSB is sign or carry
	typedef logic [FP16_FRAC_W:0]   fp16_man_t;	// Hidden bit restored
	typedef logic [FP16_FRAC_W+1:0] booth_pp_t;	// Holds 2x an 11b mantissa
	typedef logic [4:0]             lzc_t;	// 0 to 23

	// Encoding 0 unused
	typedef enum logic [1:0] {
		OP_SKIP = 2'd1,	// Internal only, zero skip of an add
		OP_MUL  = 2'd2,	// FP16 x FP16
		OP_ADD  = 2'd3	// FP29i + FP29i
	} alu_op_t;

endpackage

`default_nettype wire

//--- source/add_align.sv
/*
 * Adder front end, pipeline stages 1 and 2.
 * Stage 1 compares exponents and exchanges the mantissas so the
 * larger-exponent one becomes lhs. Stage 2 aligns the other one,
 * inverts it for a subtraction and detects the zero skip case.
 * lhs, rhs and carry_in are registered operands for the stage-3 adder.
 */
`timescale 1ns/1ps
`default_nettype none

module add_align import fpalu_pkg::*; (
	input  wire            clk,
	input  wire            a_sign,
	input  wire            b_sign,
	input  wire fp29_exp_t a_exp,
	input  wire fp29_exp_t b_exp,
	input  wire fp29_man_t a_man,
	input  wire fp29_man_t b_man,
	output sum_t           lhs,
	output sum_t           rhs,
	output logic           carry_in,
	output logic           a_exp_ge_b,
	output logic           skip
);

	logic [FP29_EXP_W:0] exp_diff;
	logic                a_ge_b;
	fp29_exp_t           shift_amt;
	fp29_exp_t           shift_r;
	fp29_man_t           big_r;
	fp29_man_t           small_r;
	logic                sub_r;
	fp29_man_t           aligned;
	sum_t                lhs_c;
	sum_t                rhs_c;

	// Borrow out of the padded difference means b has the larger exponent
	assign exp_diff  = {1'b0, a_exp} - {1'b0, b_exp};
	assign a_ge_b    = ~exp_diff[FP29_EXP_W];
	assign shift_amt = a_ge_b ? a_exp - b_exp : b_exp - a_exp;

	always_ff @(posedge clk) begin
		shift_r    <= shift_amt;
		big_r      <= a_ge_b ? a_man : b_man;	// Larger exponent
		small_r    <= a_ge_b ? b_man : a_man;	// To be aligned
		sub_r      <= a_sign ^ b_sign;	// Signs differ, subtract
		a_exp_ge_b <= a_ge_b;
	end

	// A zero at the larger exponent would wipe out the other operand
	assign skip = ~|big_r;

	// Truncating shift, anything past 21 gives zero
	assign aligned = small_r >> shift_r;

	// Skip path carries the unshifted smaller-exponent mantissa
	assign lhs_c = skip ? {1'b0, small_r} : {1'b0, big_r};
	assign rhs_c = sub_r ? ~{1'b0, aligned} : {1'b0, aligned};	// One's complement

	always_ff @(posedge clk) begin
		lhs      <= lhs_c;
		rhs      <= rhs_c;
		carry_in <= sub_r;	// Completes the two's complement
	end

endmodule

`default_nettype wire

//--- source/booth_r4_encoder.sv
/*
 * Multiplier stage 1, radix-4 Booth encoding.
 * Restores the hidden bit of both FP16 mantissas and forms the six
 * partial products of a times b. A negative digit gives the one's
 * complement of the multiple, the +1 travels in pp_sign.
 */
`timescale 1ns/1ps
`default_nettype none

module booth_r4_encoder import fpalu_pkg::*; (
	input  wire [FP16_EXP_W-1:0]        a_exp,
	input  wire [FP16_EXP_W-1:0]        b_exp,
	input  wire [FP16_FRAC_W-1:0]       a_man,
	input  wire [FP16_FRAC_W-1:0]       b_man,
	output booth_pp_t [BOOTH_DIGITS-1:0] pp,
	output logic [BOOTH_DIGITS-1:0]     pp_sign
);

	fp16_man_t                 a_full;
	fp16_man_t                 b_full;
	logic [2*BOOTH_DIGITS+1:0] b_enc;

	// Exponent zero means denormal, fraction scaled by two instead
	assign a_full = (a_exp == '0) ? {a_man, 1'b0} : {1'b1, a_man};
	assign b_full = (b_exp == '0) ? {b_man, 1'b0} : {1'b1, b_man};

	// Implicit zero below the LSB, zero padding above keeps it unsigned
	assign b_enc = {2'b00, b_full, 1'b0};

	for (genvar i = 0; i < BOOTH_DIGITS; i++) begin : gen_digit
		logic [2:0] dig;
		logic       one;
		logic       two;
		booth_pp_t  mult;

		assign dig  = b_enc[2*i+2:2*i];
		assign one  = dig[1] ^ dig[0];	// +-1
		assign two  = (dig == 3'b011) || (dig == 3'b100);	// +-2
		assign mult = one ? {1'b0, a_full} : (two ? {a_full, 1'b0} : '0);

		// 3'b111 encodes zero, kept positive
		assign pp_sign[i] = dig[2] & ~(dig[1] & dig[0]);
		assign pp[i]      = mult ^ {$bits(booth_pp_t){pp_sign[i]}};
	end

endmodule

`default_nettype wire

//--- source/booth_partial_sum.sv
/*
 * Multiplier stage 2, first level of partial product summation.
 * Captures the Booth products of a multiply and folds them into two
 * partial sums, digits 0..2 and digits 3..5 (offset by 6 bits).
 * sign2 is left over for the final add in stage 3.
 */
`timescale 1ns/1ps
`default_nettype none

module booth_partial_sum import fpalu_pkg::*; (
	input  wire                          clk,
	input  wire alu_op_t                 opcode,
	input  wire booth_pp_t [BOOTH_DIGITS-1:0] pp,
	input  wire [BOOTH_DIGITS-1:0]       pp_sign,
	output logic [18:0]                  psum0,
	output logic [15:0]                  psum1,
	output logic                         sign2
);

	booth_pp_t [BOOTH_DIGITS-1:0] pp_r;
	logic [BOOTH_DIGITS-1:0]      s_r;
	logic [18:0]                  psum0_c;
	logic [15:0]                  psum1_c;

	// Products only load on a multiply, otherwise they hold still
	always_ff @(posedge clk) begin
		if (opcode == OP_MUL) begin
			pp_r <= pp;
			s_r  <= pp_sign;
		end
	end

	// Each signed digit sign-extends through an inverted sign bit
	// at its bit 12, the matching -2^(12+2i) terms gathered in psum1
	always_comb begin
		psum0_c = {7'd0, pp_r[0]}
			+ {5'd0, pp_r[1], 2'd0}
			+ {3'd0, pp_r[2], 4'd0}
			+ {18'd0, s_r[0]}
			+ {16'd0, s_r[1], 2'd0}
			+ {2'd0, ~s_r[2], 1'b0, ~s_r[1], 1'b0, ~s_r[0], 12'd0};

		psum1_c = {4'd0, pp_r[3]}
			+ {2'd0, pp_r[4], 2'd0}
			+ {pp_r[5], 4'd0}
			+ {15'd0, s_r[3]}
			+ {13'd0, s_r[4], 2'd0}
			+ {11'd0, s_r[5], 4'd0}
			+ {1'b0, ~s_r[4], 1'b0, ~s_r[3], 12'd0}
			+ 16'haac0;	// -(2^12+..+2^20) mod 2^22, shifted down 6
	end

	always_ff @(posedge clk) begin
		psum0 <= psum0_c;
		psum1 <= psum1_c;
		sign2 <= s_r[2];	// +1 of digit 2, weight 2^4
	end

endmodule

`default_nettype wire

//--- source/shared_adder.sv
/*
 * Stage 3, the one 23-bit adder shared by both operations.
 * An add uses the aligned mantissas with carry-in for subtraction,
 * a multiply completes the Booth sum, a skip passes lhs through.
 * neg flags a negative difference for the stage-4 complement.
 */
`timescale 1ns/1ps
`default_nettype none

module shared_adder import fpalu_pkg::*; (
	input  wire alu_op_t opcode,
	input  wire sum_t    lhs,
	input  wire sum_t    rhs,
	input  wire          carry_in,
	input  wire [18:0]   psum0,
	input  wire [15:0]   psum1,
	input  wire          sign2,
	output sum_t         sum,
	output logic         neg
);

	sum_t op_l;
	sum_t op_r;
	logic op_cin;
	sum_t raw;

	always_comb begin
		if (opcode == OP_MUL) begin
			op_l   = {4'd0, psum0};
			op_r   = {1'b0, psum1, 1'b0, sign2, 4'd0};	// psum1 at bit 6
			op_cin = 1'b0;
		end else begin
			op_l   = lhs;
			op_r   = rhs;
			op_cin = carry_in;
		end
	end

	assign raw = op_l + op_r + op_cin;

	always_comb begin
		case (opcode)
			OP_ADD:  sum = raw;
			OP_MUL:  sum = {1'b0, raw[FP29_MAN_W-1:0]};	// Product is below 2^22
			OP_SKIP: sum = lhs;
			default: sum = '0;
		endcase
	end

	// Bit 22 is a carry when adding, the sign only when subtracting
	assign neg = (opcode == OP_ADD) && carry_in && raw[FP29_MAN_W];

endmodule

`default_nettype wire

//--- source/normalizer.sv
/*
 * Stage 4, normalization.
 * Turns a negative difference into its magnitude, counts the leading
 * zeros of the 23-bit result and shifts it up so the top 22 bits are
 * kept. The raw low bits are registered as well for the skip path.
 */
`timescale 1ns/1ps
`default_nettype none

module normalizer import fpalu_pkg::*; (
	input  wire       clk,
	input  wire       neg,
	input  wire sum_t sum,
	output fp29_man_t man_norm,
	output lzc_t      lzc,
	output fp29_man_t man_skip
);

	sum_t mag;
	sum_t shifted;
	lzc_t lz;

	// Leading zeros from bit 22 down, 23 for an all-zero value
	function automatic lzc_t count_lz(input sum_t v);
		lzc_t n;
		logic hit;
		n   = '0;
		hit = 1'b0;
		for (int i = FP29_MAN_W; i >= 0; i--) begin
			if (!hit) begin
				if (v[i])
					hit = 1'b1;
				else
					n = n + 1'b1;
			end
		end
		return n;
	endfunction

	assign mag     = neg ? ~sum + 1'b1 : sum;
	assign lz      = count_lz(mag);
	assign shifted = mag << lz;	// Leading one lands in bit 22

	always_ff @(posedge clk) begin
		man_norm <= shifted[FP29_MAN_W:1];	// Drops the LSB
		lzc      <= lz;
		man_skip <= sum[FP29_MAN_W-1:0];	// Untouched mantissa
	end

endmodule

`default_nettype wire

//--- source/result_assembly.sv
/*
 * Stage 5, output fields.
 * Forms the final exponent and sign for the stage-5 opcode and picks
 * the normalized or the skip mantissa. Purely combinational, drives
 * the unit outputs directly. Exponent overflow simply wraps.
 */
`timescale 1ns/1ps
`default_nettype none

module result_assembly import fpalu_pkg::*; (
	input  wire alu_op_t   opcode,
	input  wire            a_sign,
	input  wire            b_sign,
	input  wire fp29_exp_t a_exp,
	input  wire fp29_exp_t b_exp,
	input  wire            a_exp_ge_b,
	input  wire            flipped,
	input  wire fp29_man_t man_norm,
	input  wire fp29_man_t man_skip,
	input  wire lzc_t      lzc,
	output logic           y_sign,
	output fp29_exp_t      y_exp,
	output fp29_man_t      y_man
);

	fp29_exp_t exp_big;
	fp29_exp_t exp_small;
	logic      sign_big;
	logic      sign_small;

	assign exp_big    = a_exp_ge_b ? a_exp : b_exp;
	assign exp_small  = a_exp_ge_b ? b_exp : a_exp;
	assign sign_big   = a_exp_ge_b ? a_sign : b_sign;
	assign sign_small = a_exp_ge_b ? b_sign : a_sign;

	always_comb begin
		y_man = man_norm;
		case (opcode)
			OP_ADD: begin
				// Sum scale is one bit above the larger exponent
				y_exp  = exp_big + 1'b1 - lzc;
				y_sign = sign_big ^ flipped;	// Smaller operand won
			end
			OP_MUL: begin
				if (man_norm == '0) begin	// Zero product, all clear
					y_exp  = '0;
					y_sign = 1'b0;
				end else begin
					// Rebias from two FP16 exponents to FP29i
					y_exp  = a_exp + b_exp + fp29_exp_t'(FP29_BIAS + 2 - 2 * FP16_BIAS) - lzc;
					y_sign = a_sign ^ b_sign;
				end
			end
			OP_SKIP: begin
				y_exp  = exp_small;
				y_sign = sign_small;
				y_man  = man_skip;
			end
			default: begin
				y_exp  = '0;
				y_sign = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- source/fpalu_top.sv
/*
 * Five-stage FP29i adder / FP16 multiplier with one shared adder.
 * Inputs feed stage 1 directly, results leave stage 5 four clocks
 * later with y_valid. One operation per cycle, no back-pressure.
 * Opcode, signs, exponents and valid are relayed alongside the data.
 */
`timescale 1ns/1ps
`default_nettype none

module fpalu_top import fpalu_pkg::*; (
	input  wire            clk,
	input  wire            reset,
	input  wire            in_valid,
	input  wire alu_op_t   opcode,
	input  wire            a_sign,
	input  wire            b_sign,
	input  wire fp29_exp_t a_exp,
	input  wire fp29_exp_t b_exp,
	input  wire fp29_man_t a_man,
	input  wire fp29_man_t b_man,
	output logic           y_valid,
	output logic           y_sign,
	output fp29_exp_t      y_exp,
	output fp29_man_t      y_man
);

	fp29_exp_t s1_a_exp;
	fp29_exp_t s1_b_exp;

	alu_op_t   s2_op;
	logic      s2_a_sign;
	logic      s2_b_sign;
	fp29_exp_t s2_a_exp;
	fp29_exp_t s2_b_exp;
	logic      s2_valid;
	logic      s2_ge;

	alu_op_t   s3_op;
	logic      s3_a_sign;
	logic      s3_b_sign;
	fp29_exp_t s3_a_exp;
	fp29_exp_t s3_b_exp;
	logic      s3_valid;
	logic      s3_ge;

	alu_op_t   s4_op;
	logic      s4_a_sign;
	logic      s4_b_sign;
	fp29_exp_t s4_a_exp;
	fp29_exp_t s4_b_exp;
	logic      s4_valid;
	logic      s4_ge;
	sum_t      s4_sum;
	logic      s4_neg;

	alu_op_t   s5_op;
	logic      s5_a_sign;
	logic      s5_b_sign;
	fp29_exp_t s5_a_exp;
	fp29_exp_t s5_b_exp;
	logic      s5_valid;
	logic      s5_ge;
	logic      s5_flipped;

	sum_t                         lhs;
	sum_t                         rhs;
	logic                         carry_in;
	logic                         skip;
	booth_pp_t [BOOTH_DIGITS-1:0] pp;
	logic [BOOTH_DIGITS-1:0]      pp_sign;
	logic [18:0]                  psum0;
	logic [15:0]                  psum1;
	logic                         sign2;
	sum_t                         sum;
	logic                         neg;
	fp29_man_t                    man_norm;
	fp29_man_t                    man_skip;
	lzc_t                         lzc;

	// FP16 exponents live in the low 5 bits
	assign s1_a_exp = (opcode == OP_MUL) ?
		{{(FP29_EXP_W-FP16_EXP_W){1'b0}}, a_exp[FP16_EXP_W-1:0]} : a_exp;
	assign s1_b_exp = (opcode == OP_MUL) ?
		{{(FP29_EXP_W-FP16_EXP_W){1'b0}}, b_exp[FP16_EXP_W-1:0]} : b_exp;

	add_align i_add_align (
		.clk        (clk),
		.a_sign     (a_sign),
		.b_sign     (b_sign),
		.a_exp      (a_exp),
		.b_exp      (b_exp),
		.a_man      (a_man),
		.b_man      (b_man),
		.lhs        (lhs),
		.rhs        (rhs),
		.carry_in   (carry_in),
		.a_exp_ge_b (s2_ge),
		.skip       (skip)
	);

	booth_r4_encoder i_booth_enc (
		.a_exp   (a_exp[FP16_EXP_W-1:0]),
		.b_exp   (b_exp[FP16_EXP_W-1:0]),
		.a_man   (a_man[FP16_FRAC_W-1:0]),
		.b_man   (b_man[FP16_FRAC_W-1:0]),
		.pp      (pp),
		.pp_sign (pp_sign)
	);

	booth_partial_sum i_booth_sum (
		.clk     (clk),
		.opcode  (opcode),
		.pp      (pp),
		.pp_sign (pp_sign),
		.psum0   (psum0),
		.psum1   (psum1),
		.sign2   (sign2)
	);

	shared_adder i_shared_adder (
		.opcode   (s3_op),
		.lhs      (lhs),
		.rhs      (rhs),
		.carry_in (carry_in),
		.psum0    (psum0),
		.psum1    (psum1),
		.sign2    (sign2),
		.sum      (sum),
		.neg      (neg)
	);

	normalizer i_normalizer (
		.clk      (clk),
		.neg      (s4_neg),
		.sum      (s4_sum),
		.man_norm (man_norm),
		.lzc      (lzc),
		.man_skip (man_skip)
	);

	result_assembly i_result (
		.opcode     (s5_op),
		.a_sign     (s5_a_sign),
		.b_sign     (s5_b_sign),
		.a_exp      (s5_a_exp),
		.b_exp      (s5_b_exp),
		.a_exp_ge_b (s5_ge),
		.flipped    (s5_flipped),
		.man_norm   (man_norm),
		.man_skip   (man_skip),
		.lzc        (lzc),
		.y_sign     (y_sign),
		.y_exp      (y_exp),
		.y_man      (y_man)
	);

	// Relay of the per-operation fields
	always_ff @(posedge clk) begin
		s2_op     <= opcode;
		s2_a_sign <= a_sign;
		s2_b_sign <= b_sign;
		s2_a_exp  <= s1_a_exp;
		s2_b_exp  <= s1_b_exp;

		// Zero at the larger exponent turns an add into a pass-through
		s3_op     <= (s2_op == OP_ADD && skip) ? OP_SKIP : s2_op;
		s3_a_sign <= s2_a_sign;
		s3_b_sign <= s2_b_sign;
		s3_a_exp  <= s2_a_exp;
		s3_b_exp  <= s2_b_exp;
		s3_ge     <= s2_ge;

		s4_op     <= s3_op;
		s4_a_sign <= s3_a_sign;
		s4_b_sign <= s3_b_sign;
		s4_a_exp  <= s3_a_exp;
		s4_b_exp  <= s3_b_exp;
		s4_ge     <= s3_ge;
		s4_sum    <= sum;
		s4_neg    <= neg;

		s5_op      <= s4_op;
		s5_a_sign  <= s4_a_sign;
		s5_b_sign  <= s4_b_sign;
		s5_a_exp   <= s4_a_exp;
		s5_b_exp   <= s4_b_exp;
		s5_ge      <= s4_ge;
		s5_flipped <= s4_neg;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			s2_valid <= 1'b0;
			s3_valid <= 1'b0;
			s4_valid <= 1'b0;
			s5_valid <= 1'b0;
		end else begin
			s2_valid <= in_valid;
			s3_valid <= s2_valid;
			s4_valid <= s3_valid;
			s5_valid <= s4_valid;
		end
	end

	assign y_valid = s5_valid;	// Four clocks after in_valid

endmodule

`default_nettype wire

//--- testbench/clock_gen.sv
/*
 * Free-running testbench clock.
 * 20 ns period, starts low so the first rising edge is at 10 ns.
 */
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
	output logic clk
);

	initial clk = 1'b0;

	always #10 clk = ~clk;	// Half period

endmodule

`default_nettype wire

//--- testbench/fpalu_tb.sv
/*
 * Testbench for the FP29i add / FP16 multiply unit.
 * Hand-worked table entries, then seeded random operands, go in one per
 * cycle on falling edges. Results are matched in order against a queue
 * of expected entries, with the four-cycle latency checked as well.
 */
`timescale 1ns/1ps
`default_nettype none

module fpalu_tb import fpalu_pkg::*; ();

	localparam int MAX_ENTRIES = 48;
	localparam int TIMEOUT     = 50;	// Cycles per wait
	localparam int LATENCY     = 4;

	logic      clk;
	logic      reset;
	logic      in_valid;
	alu_op_t   opcode;
	logic      a_sign;
	logic      b_sign;
	fp29_exp_t a_exp;
	fp29_exp_t b_exp;
	fp29_man_t a_man;
	fp29_man_t b_man;
	logic      y_valid;
	logic      y_sign;
	fp29_exp_t y_exp;
	fp29_man_t y_man;

	// Operation table, stimulus and expected fields
	string     t_name[MAX_ENTRIES];
	alu_op_t   t_op[MAX_ENTRIES];
	logic      t_as[MAX_ENTRIES];
	logic      t_bs[MAX_ENTRIES];
	fp29_exp_t t_ae[MAX_ENTRIES];
	fp29_exp_t t_be[MAX_ENTRIES];
	fp29_man_t t_am[MAX_ENTRIES];
	fp29_man_t t_bm[MAX_ENTRIES];
	logic      t_ys[MAX_ENTRIES];
	fp29_exp_t t_ye[MAX_ENTRIES];
	fp29_man_t t_ym[MAX_ENTRIES];

	int     n_entries = 0;
	int     n_table   = 0;	// Hand-worked part
	int     idx_q[$];	// Entry per operation in flight
	int     cyc_q[$];	// Cycle it was driven in
	int     cyc       = 0;
	int     errors    = 0;
	int     checked   = 0;
	bit     checking  = 1'b0;
	bit     timed_out;
	integer seed;

	clock_gen i_clk (.clk(clk));

	fpalu_top i_dut (
		.clk      (clk),
		.reset    (reset),
		.in_valid (in_valid),
		.opcode   (opcode),
		.a_sign   (a_sign),
		.b_sign   (b_sign),
		.a_exp    (a_exp),
		.b_exp    (b_exp),
		.a_man    (a_man),
		.b_man    (b_man),
		.y_valid  (y_valid),
		.y_sign   (y_sign),
		.y_exp    (y_exp),
		.y_man    (y_man)
	);

	always @(posedge clk) cyc <= cyc + 1;

	// Zeros above the leading one of a 23-bit value
	function automatic int count_leading_zeros(input int v);
		int n;
		n = 0;
		while (n < 23 && v[22 - n] == 1'b0)
			n++;
		return n;
	endfunction

	// Expected result by integer arithmetic
	task automatic model_result(input alu_op_t op, input logic as, input int ae, input int am,
		input logic bs, input int be, input int bm,
		output logic ys, output fp29_exp_t ye, output fp29_man_t ym);
		int   e_big;
		int   e_small;
		int   m_big;
		int   m_small;
		logic s_big;
		logic s_small;
		int   fa;
		int   fb;
		int   s;
		int   lz;
		logic neg;
		if (op == OP_MUL) begin
			fa = ((ae & 31) == 0) ? (am & 1023) * 2 : 1024 + (am & 1023);	// Hidden one
			fb = ((be & 31) == 0) ? (bm & 1023) * 2 : 1024 + (bm & 1023);
			s  = fa * fb;
			lz = count_leading_zeros(s);
			ys = (s == 0) ? 1'b0 : as ^ bs;
			ye = (s == 0) ? '0 : fp29_exp_t'((ae & 31) + (be & 31) + FP29_BIAS + 2
				- 2 * FP16_BIAS - lz);
			ym = fp29_man_t'(((s << lz) & 'h7fffff) >> 1);
		end else begin
			e_big   = (ae >= be) ? ae : be;
			e_small = (ae >= be) ? be : ae;
			m_big   = (ae >= be) ? am : bm;
			m_small = (ae >= be) ? bm : am;
			s_big   = (ae >= be) ? as : bs;
			s_small = (ae >= be) ? bs : as;
			if (m_big == 0) begin	// Zero skip, other operand as is
				ys = s_small;
				ye = fp29_exp_t'(e_small);
				ym = fp29_man_t'(m_small);
			end else begin
				m_small = m_small >> (e_big - e_small);	// Truncating alignment
				neg     = (as != bs) && (m_small > m_big);
				if (as == bs)
					s = m_big + m_small;
				else
					s = neg ? m_small - m_big : m_big - m_small;
				lz = count_leading_zeros(s);
				ys = s_big ^ neg;
				ye = fp29_exp_t'(e_big + 1 - lz);
				ym = fp29_man_t'(((s << lz) & 'h7fffff) >> 1);
			end
		end
	endtask

	task automatic add_entry(input string name, input alu_op_t op,
		input logic as, input int ae, input int am, input logic bs, input int be, input int bm,
		input logic ys, input int ye, input int ym);
		t_name[n_entries] = name;
		t_op[n_entries]   = op;
		t_as[n_entries]   = as;
		t_ae[n_entries]   = fp29_exp_t'(ae);
		t_am[n_entries]   = fp29_man_t'(am);
		t_bs[n_entries]   = bs;
		t_be[n_entries]   = fp29_exp_t'(be);
		t_bm[n_entries]   = fp29_man_t'(bm);
		t_ys[n_entries]   = ys;
		t_ye[n_entries]   = fp29_exp_t'(ye);
		t_ym[n_entries]   = fp29_man_t'(ym);
		n_entries++;
	endtask

	// Mostly FP16 multiplies, every third an FP29i add
	task automatic add_random_entries(input int count);
		logic [31:0] r;
		logic [31:0] q;
		logic        ys;
		fp29_exp_t   ye;
		fp29_man_t   ym;
		int          ae;
		int          be;
		for (int k = 0; k < count; k++) begin
			r = $random(seed);
			q = $random(seed);
			if (k % 3 == 2) begin
				ae = r[5:0];
				be = (ae + q[3:0] - 8) & 63;	// Close exponents
				model_result(OP_ADD, r[28], ae, r[27:6], q[26], be, q[25:4], ys, ye, ym);
				add_entry($sformatf("rand_add_%0d", k), OP_ADD, r[28], ae, r[27:6],
					q[26], be, q[25:4], ys, ye, ym);
			end else begin
				ae = (q[1:0] == 2'd0) ? 0 : r[4:0];	// Some denormals
				be = (q[3:2] == 2'd0) ? 0 : r[9:5];
				model_result(OP_MUL, r[30], ae, r[19:10], r[31], be, r[29:20], ys, ye, ym);
				add_entry($sformatf("rand_mul_%0d", k), OP_MUL, r[30], ae, r[19:10],
					r[31], be, r[29:20], ys, ye, ym);
			end
		end
	endtask

	task automatic apply_entry(input int i);
		opcode   = t_op[i];
		a_sign   = t_as[i];
		a_exp    = t_ae[i];
		a_man    = t_am[i];
		b_sign   = t_bs[i];
		b_exp    = t_be[i];
		b_man    = t_bm[i];
		in_valid = 1'b1;
		idx_q.push_back(i);
		cyc_q.push_back(cyc);
	endtask

	// Once per falling edge, outputs settled since the rising edge
	task automatic check_output();
		int idx;
		int due;
		if (y_valid === 1'b1) begin
			if (idx_q.size() == 0) begin
				errors++;
				$display("y_valid high with no operation outstanding at cycle %0d", cyc);
			end else begin
				idx = idx_q.pop_front();
				due = cyc_q.pop_front() + LATENCY;
				checked++;
				if (cyc != due) begin
					errors++;
					$display("error %s latency: expected %0d, actual %0d", t_name[idx],
						LATENCY, cyc - due + LATENCY);
				end
				if (y_sign !== t_ys[idx] || y_exp !== t_ye[idx] || y_man !== t_ym[idx]) begin
					errors++;
					$display("error %s: expected %b/%h/%h, actual %b/%h/%h", t_name[idx],
						t_ys[idx], t_ye[idx], t_ym[idx], y_sign, y_exp, y_man);
				end
			end
		end else if (y_valid !== 1'b0) begin
			errors++;
			$display("y_valid is unknown at cycle %0d", cyc);
		end else if (cyc_q.size() != 0 && cyc_q[0] + LATENCY <= cyc) begin
			errors++;
			$display("result of %s did not appear on time", t_name[idx_q[0]]);
			void'(idx_q.pop_front());	// Drop it, keep order for the rest
			void'(cyc_q.pop_front());
		end
	endtask

	always @(negedge clk) begin
		if (checking)
			check_output();
	end

	task automatic wait_for_drain(output bit late);
		int n;
		n = 0;
		while (idx_q.size() != 0 && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		late = (idx_q.size() != 0);
	endtask

	initial begin
		reset    = 1'b1;
		in_valid = 1'b0;
		opcode   = OP_ADD;
		a_sign   = 1'b0;
		b_sign   = 1'b0;
		a_exp    = '0;
		b_exp    = '0;
		a_man    = '0;
		b_man    = '0;
		seed     = 18007;

		// name, op, a sign/exp/man, b sign/exp/man, expected sign/exp/man
		add_entry("add_same_sign", OP_ADD, 0, 'h21, 'h200000, 0, 'h1f, 'h200000, 0, 'h21, 'h280000);
		add_entry("mul_one_one", OP_MUL, 0, 'h0f, 'h000, 0, 'h0f, 'h000, 0, 'h1f, 'h200000);
		add_entry("add_carry", OP_ADD, 0, 'h14, 'h300000, 0, 'h14, 'h100000, 0, 'h15, 'h200000);
		add_entry("mul_normal_mixed", OP_MUL, 1, 'h10, 'h200, 0, 'h0e, 'h300, 1, 'h20, 'h2a0000);
		add_entry("add_b_larger_exp", OP_ADD, 1, 'h0a, 'h000400, 1, 'h0e, 'h001000, 1, 'h05, 'h208000);
		add_entry("mul_denormal", OP_MUL, 0, 'h00, 'h001, 1, 'h0f, 'h000, 1, 'h07, 'h200000);
		add_entry("sub_small_wins_a", OP_ADD, 0, 'h0c, 'h040000, 1, 'h0b, 'h3c0000, 1, 'h0b, 'h340000);
		add_entry("mul_both_denormal", OP_MUL, 1, 'h00, 'h3ff, 1, 'h00, 'h200, 0, 'h01, 'h3ff000);
		add_entry("skip_a_zero", OP_ADD, 0, 'h32, 'h000000, 1, 'h14, 'h012345, 1, 'h14, 'h012345);
		add_entry("mul_zero", OP_MUL, 1, 'h00, 'h000, 0, 'h14, 'h155, 0, 'h00, 'h000000);
		add_entry("sub_big_wins", OP_ADD, 0, 'h28, 'h300000, 1, 'h27, 'h200000, 0, 'h28, 'h200000);
		add_entry("sub_small_wins_b", OP_ADD, 1, 'h05, 'h3ff000, 0, 'h08, 'h000800, 1, 'h05, 'h3fb000);
		add_entry("mul_max", OP_MUL, 0, 'h1e, 'h3ff, 0, 'h1e, 'h3ff, 0, 'h3e, 'h3ff001);
		add_entry("skip_b_zero", OP_ADD, 1, 'h03, 'h2abcde, 0, 'h09, 'h000000, 1, 'h03, 'h2abcde);
		n_table = n_entries;
		add_random_entries(24);

		repeat (2) @(posedge clk);	// Two reset cycles
		@(negedge clk);
		reset    = 1'b0;
		checking = 1'b1;
		if (y_valid !== 1'b0) begin
			errors++;
			$display("y_valid not low after reset");
		end

		for (int i = 0; i < n_entries; i++) begin
			if (i == n_table) begin	// Idle gap before the random part
				@(negedge clk);
				in_valid = 1'b0;
				repeat (2) @(negedge clk);
			end
			@(negedge clk);
			apply_entry(i);
		end
		@(negedge clk);
		in_valid = 1'b0;

		wait_for_drain(timed_out);
		if (timed_out) begin
			errors++;
			$display("timeout waiting for %0d outstanding results", idx_q.size());
		end
		repeat (LATENCY + 2) @(negedge clk);	// No stray y_valid afterwards

		$display("%0d errors, %0d of %0d results checked", errors, checked, n_entries);
		if (errors == 0 && checked == n_entries)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
source/fpalu_pkg.sv
source/add_align.sv
source/booth_r4_encoder.sv
source/booth_partial_sum.sv
source/shared_adder.sv
source/normalizer.sv
source/result_assembly.sv
source/fpalu_top.sv
testbench/clock_gen.sv
testbench/fpalu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the FP ALU testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module fpalu_tb -f compile.f -o fpalu_sim \
	&& ./obj_dir/fpalu_sim > sim.log 2>&1 \
	|| { echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "Checks failed" sim.log && { echo "Simulation FAILED"; exit 1; } \
	|| { echo "Simulation passed"; exit 0; }
